/* all.f */
+incdir+src
src/rv_isa_pkg.sv
src/rv_pipe_pkg.sv
src/rv_pipe_if.sv
src/rv_wb_port.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_core_top.sv
test/rv_core_assert.sv
test/rv_core_tb.sv

/* src/rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Datapath width and architectural register count
`define RV_XLEN 32
`define RV_NREGS 32

// Wishbone word addresses
`define RV_ADDR_INSN 0 // Write issues an instruction
`define RV_ADDR_RETIRED 1 // Read returns retire count

`endif

/* src/rv_core_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module rv_core_top (
	input  logic clk_i,
	input  logic rst_ni,
	input  logic wb_cyc_i,
	input  logic wb_stb_i,
	input  logic wb_we_i,
	input  logic [`RV_XLEN-1:0] wb_adr_i,
	input  logic [`RV_XLEN-1:0] wb_dat_i,
	output logic [`RV_XLEN-1:0] wb_dat_o,
	output logic wb_ack_o,
	output logic retire_valid_o,
	output logic retire_we_o,
	output logic [$clog2(`RV_NREGS)-1:0] retire_rd_o,
	output logic [`RV_XLEN-1:0] retire_data_o,
	output logic branch_taken_o
);

	logic issue;
	logic [`RV_XLEN-1:0] insn;
	logic [`RV_XLEN-1:0] retired;
	logic wb_we;
	logic [$clog2(`RV_NREGS)-1:0] wb_rd;
	logic [`RV_XLEN-1:0] wb_data;

	id_ex_if id_ex ();
	ex_res_if ex_res ();

	rv_wb_port rv_wb_port_i (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.wb_cyc_i  (wb_cyc_i),
		.wb_stb_i  (wb_stb_i),
		.wb_we_i   (wb_we_i),
		.wb_adr_i  (wb_adr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_dat_o  (wb_dat_o),
		.wb_ack_o  (wb_ack_o),
		.issue_o   (issue),
		.insn_o    (insn),
		.retired_i (retired)
	);

	rv_decode rv_decode_i (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.issue_i   (issue),
		.insn_i    (insn),
		.wb_we_i   (wb_we),
		.wb_rd_i   (wb_rd),
		.wb_data_i (wb_data),
		.id_ex     (id_ex.out)
	);

	rv_execute rv_execute_i (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.id_ex     (id_ex.in),
		.ex_res    (ex_res.out),
		.wb_we_i   (wb_we),
		.wb_rd_i   (wb_rd),
		.wb_data_i (wb_data)
	);

	rv_result rv_result_i (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.ex_res         (ex_res.in),
		.wb_we_o        (wb_we),
		.wb_rd_o        (wb_rd),
		.wb_data_o      (wb_data),
		.retire_valid_o (retire_valid_o),
		.branch_taken_o (branch_taken_o),
		.retired_o      (retired)
	);

	// Writeback doubles as the retire report
	assign retire_we_o = wb_we;
	assign retire_rd_o = wb_rd;
	assign retire_data_o = wb_data;

endmodule

`default_nettype wire

/* src/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module rv_decode (
	input  logic clk_i,
	input  logic rst_ni,
	input  logic issue_i,
	input  logic [`RV_XLEN-1:0] insn_i,
	input  logic wb_we_i,
	input  logic [$clog2(`RV_NREGS)-1:0] wb_rd_i,
	input  logic [`RV_XLEN-1:0] wb_data_i,
	id_ex_if.out id_ex
);

	localparam int RW = $clog2(`RV_NREGS);

	logic valid_q;
	logic [`RV_XLEN-1:0] insn_q, pc_q, pc_next;
	logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];
	logic [RW-1:0] rs1, rs2, rd;
	logic [2:0] funct3;
	logic f7b5;
	rv_isa_pkg::rv_opcode_e opcode;
	logic [`RV_XLEN-1:0] imm_i, imm_u, imm_b, imm_j;
	logic [`RV_XLEN-1:0] imm;
	rv_isa_pkg::rv_alu_op_e alu_op;
	logic a_sel, b_sel, br;
	rv_pipe_pkg::rv_wb_sel_e wb_sel;

	// Instruction register, loaded on the bus accept edge
	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			valid_q <= 1'b0;
			pc_next <= '0;
		end else begin
			valid_q <= issue_i;
			if (issue_i) begin
				pc_next <= pc_next + `RV_XLEN'd4;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (issue_i) begin
			insn_q <= insn_i;
			pc_q <= pc_next;
		end
	end

	assign opcode = rv_isa_pkg::rv_opcode_e'(insn_q[6:0]);
	assign rd = insn_q[11:7];
	assign funct3 = insn_q[14:12];
	assign rs1 = insn_q[19:15];
	assign rs2 = insn_q[24:20];
	assign f7b5 = insn_q[30];

	assign imm_i = {{(`RV_XLEN-12){insn_q[31]}}, insn_q[31:20]};
	assign imm_u = {insn_q[31:12], 12'b0};
	assign imm_b = {{(`RV_XLEN-12){insn_q[31]}}, insn_q[7], insn_q[30:25], insn_q[11:8], 1'b0};
	assign imm_j = {{(`RV_XLEN-20){insn_q[31]}}, insn_q[19:12], insn_q[20], insn_q[30:21], 1'b0};

	always_comb begin
		alu_op = rv_isa_pkg::ALU_ADD;
		a_sel = 1'b0;
		b_sel = 1'b0;
		br = 1'b0;
		imm = imm_i;
		wb_sel = rv_pipe_pkg::WB_NONE; // Unknown opcodes retire as bubbles
		case (opcode)
			rv_isa_pkg::OPC_OP: begin
				alu_op = rv_isa_pkg::rv_alu_op_e'({f7b5, funct3});
				wb_sel = rv_pipe_pkg::WB_ALU;
			end
			rv_isa_pkg::OPC_OP_IMM: begin
				// funct7 only meaningful for the right shifts
				alu_op = rv_isa_pkg::rv_alu_op_e'({f7b5 & (funct3 == 3'b101), funct3});
				b_sel = 1'b1;
				wb_sel = rv_pipe_pkg::WB_ALU;
			end
			rv_isa_pkg::OPC_LUI: begin
				alu_op = rv_isa_pkg::ALU_PASS_B;
				b_sel = 1'b1;
				imm = imm_u;
				wb_sel = rv_pipe_pkg::WB_ALU;
			end
			rv_isa_pkg::OPC_AUIPC: begin
				a_sel = 1'b1;
				b_sel = 1'b1;
				imm = imm_u;
				wb_sel = rv_pipe_pkg::WB_ALU;
			end
			rv_isa_pkg::OPC_JAL: begin
				a_sel = 1'b1; // ALU forms the target, rd gets pc+4
				b_sel = 1'b1;
				imm = imm_j;
				wb_sel = rv_pipe_pkg::WB_PC4;
			end
			rv_isa_pkg::OPC_BRANCH: begin
				a_sel = 1'b1;
				b_sel = 1'b1;
				imm = imm_b;
				br = 1'b1;
			end
			default: ;
		endcase
	end

	// Register file, x0 not stored
	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			for (int i = 1; i < `RV_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_we_i && wb_rd_i != '0) begin
			regs[wb_rd_i] <= wb_data_i;
		end
	end

	// Write-first read
	function automatic logic [`RV_XLEN-1:0] read_reg(input logic [RW-1:0] idx);
		if (idx == '0) begin
			return '0;
		end
		if (wb_we_i && wb_rd_i == idx) begin
			return wb_data_i;
		end
		return regs[idx];
	endfunction

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			id_ex.valid <= 1'b0;
		end else begin
			id_ex.valid <= valid_q;
		end
	end

	always_ff @(posedge clk_i) begin
		id_ex.pc <= pc_q;
		id_ex.pc4 <= pc_q + `RV_XLEN'd4;
		id_ex.rs1_val <= read_reg(rs1);
		id_ex.rs2_val <= read_reg(rs2);
		id_ex.imm <= imm;
		id_ex.rs1 <= rs1;
		id_ex.rs2 <= rs2;
		id_ex.rd <= rd;
		id_ex.alu_op <= alu_op;
		id_ex.a_sel <= a_sel;
		id_ex.b_sel <= b_sel;
		id_ex.wb_sel <= wb_sel;
		id_ex.br <= br;
		id_ex.br_cond <= rv_isa_pkg::rv_br_cond_e'(funct3);
	end

endmodule

`default_nettype wire

/* src/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module rv_execute (
	input  logic clk_i,
	input  logic rst_ni,
	id_ex_if.in id_ex,
	ex_res_if.out ex_res,
	input  logic wb_we_i,
	input  logic [$clog2(`RV_NREGS)-1:0] wb_rd_i,
	input  logic [`RV_XLEN-1:0] wb_data_i
);

	localparam int RW = $clog2(`RV_NREGS);

	logic exe_we;
	logic [`RV_XLEN-1:0] exe_data;
	rv_pipe_pkg::rv_fwd_sel_e fwd_a, fwd_b;
	logic [`RV_XLEN-1:0] rs1_fwd, rs2_fwd;
	logic [`RV_XLEN-1:0] op_a, op_b, alu;
	logic br_un, br_eq, br_lt;

	function automatic rv_pipe_pkg::rv_fwd_sel_e fwd_sel(
		input logic [RW-1:0] idx,
		input logic ex_we,
		input logic [RW-1:0] ex_rd,
		input logic res_we,
		input logic [RW-1:0] res_rd
	);
		if (idx == '0) begin
			return rv_pipe_pkg::FWD_REG;
		end
		if (ex_we && ex_rd == idx) begin
			return rv_pipe_pkg::FWD_EXE; // Youngest producer wins
		end
		if (res_we && res_rd == idx) begin
			return rv_pipe_pkg::FWD_WB;
		end
		return rv_pipe_pkg::FWD_REG;
	endfunction

	function automatic logic [`RV_XLEN-1:0] fwd_mux(
		input rv_pipe_pkg::rv_fwd_sel_e sel,
		input logic [`RV_XLEN-1:0] reg_val,
		input logic [`RV_XLEN-1:0] ex_val,
		input logic [`RV_XLEN-1:0] wb_val
	);
		case (sel)
			rv_pipe_pkg::FWD_EXE: return ex_val;
			rv_pipe_pkg::FWD_WB: return wb_val;
			default: return reg_val;
		endcase
	endfunction

	// In-flight result held in the execute register
	assign exe_we = ex_res.valid && ex_res.wb_sel != rv_pipe_pkg::WB_NONE;
	assign exe_data = (ex_res.wb_sel == rv_pipe_pkg::WB_PC4) ? ex_res.pc4 : ex_res.alu;

	assign fwd_a = fwd_sel(id_ex.rs1, exe_we, ex_res.rd, wb_we_i, wb_rd_i);
	assign fwd_b = fwd_sel(id_ex.rs2, exe_we, ex_res.rd, wb_we_i, wb_rd_i);
	assign rs1_fwd = fwd_mux(fwd_a, id_ex.rs1_val, exe_data, wb_data_i);
	assign rs2_fwd = fwd_mux(fwd_b, id_ex.rs2_val, exe_data, wb_data_i);

	assign op_a = id_ex.a_sel ? id_ex.pc : rs1_fwd;
	assign op_b = id_ex.b_sel ? id_ex.imm : rs2_fwd;

	always_comb begin
		case (id_ex.alu_op)
			rv_isa_pkg::ALU_SUB: alu = op_a - op_b;
			rv_isa_pkg::ALU_SLL: alu = op_a << op_b[4:0];
			rv_isa_pkg::ALU_SLT: alu = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			rv_isa_pkg::ALU_SLTU: alu = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
			rv_isa_pkg::ALU_XOR: alu = op_a ^ op_b;
			rv_isa_pkg::ALU_SRL: alu = op_a >> op_b[4:0];
			rv_isa_pkg::ALU_SRA: alu = $unsigned($signed(op_a) >>> op_b[4:0]);
			rv_isa_pkg::ALU_OR: alu = op_a | op_b;
			rv_isa_pkg::ALU_AND: alu = op_a & op_b;
			rv_isa_pkg::ALU_PASS_B: alu = op_b;
			default: alu = op_a + op_b;
		endcase
	end

	// Branch compare always on the forwarded registers
	assign br_un = (id_ex.br_cond == rv_isa_pkg::BR_BLTU) ||
		(id_ex.br_cond == rv_isa_pkg::BR_BGEU);
	assign br_eq = (rs1_fwd == rs2_fwd);
	assign br_lt = br_un ? (rs1_fwd < rs2_fwd) : ($signed(rs1_fwd) < $signed(rs2_fwd));

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			ex_res.valid <= 1'b0;
		end else begin
			ex_res.valid <= id_ex.valid;
		end
	end

	always_ff @(posedge clk_i) begin
		ex_res.alu <= alu;
		ex_res.pc4 <= id_ex.pc4;
		ex_res.rd <= id_ex.rd;
		ex_res.wb_sel <= id_ex.wb_sel;
		ex_res.br <= id_ex.br;
		ex_res.br_cond <= id_ex.br_cond;
		ex_res.br_eq <= br_eq;
		ex_res.br_lt <= br_lt;
	end

endmodule

`default_nettype wire

/* src/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

	// Major opcodes handled by the pipeline
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_BRANCH = 7'b1100011
	} rv_opcode_e;

	// Encoded as {funct7[5], funct3} for the register forms
	typedef enum logic [3:0] {
		ALU_ADD    = 4'b0000,
		ALU_SLL    = 4'b0001,
		ALU_SLT    = 4'b0010,
		ALU_SLTU   = 4'b0011,
		ALU_XOR    = 4'b0100,
		ALU_SRL    = 4'b0101,
		ALU_OR     = 4'b0110,
		ALU_AND    = 4'b0111,
		ALU_SUB    = 4'b1000,
		ALU_SRA    = 4'b1101,
		ALU_PASS_B = 4'b1111 // LUI
	} rv_alu_op_e;

	// Branch funct3
	typedef enum logic [2:0] {
		BR_BEQ  = 3'b000,
		BR_BNE  = 3'b001,
		BR_BLT  = 3'b100,
		BR_BGE  = 3'b101,
		BR_BLTU = 3'b110,
		BR_BGEU = 3'b111
	} rv_br_cond_e;

endpackage

`default_nettype wire

/* src/rv_pipe_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

// Decode to execute
interface id_ex_if;
	localparam int RW = $clog2(`RV_NREGS);

	logic valid;
	logic [`RV_XLEN-1:0] pc, pc4;
	logic [`RV_XLEN-1:0] rs1_val, rs2_val, imm;
	logic [RW-1:0] rs1, rs2, rd;
	rv_isa_pkg::rv_alu_op_e alu_op;
	logic a_sel; // 1 selects pc
	logic b_sel; // 1 selects imm
	rv_pipe_pkg::rv_wb_sel_e wb_sel;
	logic br;
	rv_isa_pkg::rv_br_cond_e br_cond;

	modport out (output valid, pc, pc4, rs1_val, rs2_val, imm, rs1, rs2, rd,
		alu_op, a_sel, b_sel, wb_sel, br, br_cond);
	modport in (input valid, pc, pc4, rs1_val, rs2_val, imm, rs1, rs2, rd,
		alu_op, a_sel, b_sel, wb_sel, br, br_cond);
endinterface

// Execute to result
interface ex_res_if;
	localparam int RW = $clog2(`RV_NREGS);

	logic valid;
	logic [`RV_XLEN-1:0] alu, pc4;
	logic [RW-1:0] rd;
	rv_pipe_pkg::rv_wb_sel_e wb_sel;
	logic br;
	rv_isa_pkg::rv_br_cond_e br_cond;
	logic br_eq, br_lt;

	modport out (output valid, alu, pc4, rd, wb_sel, br, br_cond, br_eq, br_lt);
	modport in (input valid, alu, pc4, rd, wb_sel, br, br_cond, br_eq, br_lt);
endinterface

`default_nettype wire

/* src/rv_pipe_pkg.sv */
`default_nettype none

package rv_pipe_pkg;

	// Source of an execute operand
	typedef enum logic [1:0] {
		FWD_REG = 2'b00, // Register file value
		FWD_EXE = 2'b01, // Execute register result
		FWD_WB  = 2'b10 // Writeback data
	} rv_fwd_sel_e;

	// What gets written to rd
	typedef enum logic [1:0] {
		WB_ALU  = 2'b00,
		WB_PC4  = 2'b01,
		WB_NONE = 2'b10
	} rv_wb_sel_e;

endpackage

`default_nettype wire

/* src/rv_result.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module rv_result (
	input  logic clk_i,
	input  logic rst_ni,
	ex_res_if.in ex_res,
	output logic wb_we_o,
	output logic [$clog2(`RV_NREGS)-1:0] wb_rd_o,
	output logic [`RV_XLEN-1:0] wb_data_o,
	output logic retire_valid_o,
	output logic branch_taken_o,
	output logic [`RV_XLEN-1:0] retired_o
);

	logic valid_q, br_q, br_eq_q, br_lt_q, taken;
	logic [`RV_XLEN-1:0] alu_q, pc4_q;
	rv_pipe_pkg::rv_wb_sel_e wb_sel_q;
	rv_isa_pkg::rv_br_cond_e br_cond_q;

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			valid_q <= 1'b0;
			retired_o <= '0;
		end else begin
			valid_q <= ex_res.valid;
			if (ex_res.valid) begin
				retired_o <= retired_o + 1'b1; // Counts with the retire it belongs to
			end
		end
	end

	always_ff @(posedge clk_i) begin
		alu_q <= ex_res.alu;
		pc4_q <= ex_res.pc4;
		wb_rd_o <= ex_res.rd;
		wb_sel_q <= ex_res.wb_sel;
		br_q <= ex_res.br;
		br_cond_q <= ex_res.br_cond;
		br_eq_q <= ex_res.br_eq;
		br_lt_q <= ex_res.br_lt;
	end

	always_comb begin
		case (br_cond_q)
			rv_isa_pkg::BR_BEQ: taken = br_eq_q;
			rv_isa_pkg::BR_BNE: taken = !br_eq_q;
			rv_isa_pkg::BR_BLT, rv_isa_pkg::BR_BLTU: taken = br_lt_q;
			rv_isa_pkg::BR_BGE, rv_isa_pkg::BR_BGEU: taken = !br_lt_q;
			default: taken = 1'b0;
		endcase
	end

	assign wb_we_o = valid_q && wb_sel_q != rv_pipe_pkg::WB_NONE && wb_rd_o != '0;
	assign wb_data_o = (wb_sel_q == rv_pipe_pkg::WB_PC4) ? pc4_q : alu_q;
	assign retire_valid_o = valid_q;
	assign branch_taken_o = valid_q & br_q & taken; // Reported only, no redirect

endmodule

`default_nettype wire

/* src/rv_wb_port.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module rv_wb_port (
	input  logic clk_i,
	input  logic rst_ni,
	input  logic wb_cyc_i,
	input  logic wb_stb_i,
	input  logic wb_we_i,
	input  logic [`RV_XLEN-1:0] wb_adr_i,
	input  logic [`RV_XLEN-1:0] wb_dat_i,
	output logic [`RV_XLEN-1:0] wb_dat_o,
	output logic wb_ack_o,
	output logic issue_o,
	output logic [`RV_XLEN-1:0] insn_o,
	input  logic [`RV_XLEN-1:0] retired_i
);

	logic req;
	logic ack_q;
	logic hit_insn, hit_retired;

	assign req = wb_cyc_i & wb_stb_i;

	// One ack per request, never twice in a row
	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req & ~ack_q;
		end
	end

	// Ack falls as soon as the master lets go
	assign wb_ack_o = ack_q & req;

	assign hit_insn = (wb_adr_i == `RV_ADDR_INSN);
	assign hit_retired = (wb_adr_i == `RV_ADDR_RETIRED);

	// Accepted write to the instruction address
	assign issue_o = wb_ack_o & wb_we_i & hit_insn;
	assign insn_o = wb_dat_i;

	// Other addresses read as zero
	always_comb begin
		wb_dat_o = '0;
		if (hit_retired) begin
			wb_dat_o = retired_i;
		end
	end

endmodule

`default_nettype wire

/* test/rv_core_assert.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module rv_core_assert (
	input logic clk_i,
	input logic rst_ni,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input logic [`RV_XLEN-1:0] wb_adr_i,
	input logic wb_ack_i,
	input logic retire_valid_i,
	input logic retire_we_i,
	input logic [$clog2(`RV_NREGS)-1:0] retire_rd_i
);

	int fails = 0; // Failed assertion count
	logic req, accept;

	assign req = wb_cyc_i & wb_stb_i;
	assign accept = req & wb_we_i & wb_ack_i & (wb_adr_i == `RV_ADDR_INSN);

	ack_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
		wb_ack_i |-> $past(req))
		else begin
			fails++;
			$error("Ack without a request in the previous cycle");
		end

	ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
		wb_ack_i |=> !wb_ack_i)
		else begin
			fails++;
			$error("Ack high for two cycles in a row");
		end

	accept_retires: assert property (@(posedge clk_i) disable iff (!rst_ni)
		accept |-> ##4 retire_valid_i)
		else begin
			fails++;
			$error("Accepted instruction did not retire four edges later");
		end

	retire_from_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
		retire_valid_i |-> $past(accept, 4))
		else begin
			fails++;
			$error("Retire without an accepted write four edges earlier");
		end

	no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
		retire_we_i |-> retire_rd_i != '0)
		else begin
			fails++;
			$error("Register write to x0");
		end

endmodule

bind rv_core_top rv_core_assert rv_core_assert_i (
	.clk_i          (clk_i),
	.rst_ni         (rst_ni),
	.wb_cyc_i       (wb_cyc_i),
	.wb_stb_i       (wb_stb_i),
	.wb_we_i        (wb_we_i),
	.wb_adr_i       (wb_adr_i),
	.wb_ack_i       (wb_ack_o),
	.retire_valid_i (retire_valid_o),
	.retire_we_i    (retire_we_o),
	.retire_rd_i    (retire_rd_o)
);

`default_nettype wire

/* test/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module rv_core_tb;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_TESTS = 6;
	localparam int MAX_INSNS = 64; // Per test
	localparam int TIMEOUT_NS = (RESET_CYCLES + NUM_TESTS * MAX_INSNS * 12) * CLK_PERIOD;
	localparam int RW = $clog2(`RV_NREGS);

	logic clk, rst_n;
	logic wb_cyc, wb_stb, wb_we, wb_ack;
	logic [`RV_XLEN-1:0] wb_adr, wb_dat_w, wb_dat_r;
	logic retire_valid, retire_we, branch_taken;
	logic [RW-1:0] retire_rd;
	logic [`RV_XLEN-1:0] retire_data;

	int seed = 42593;
	int errors = 0;
	string test_name = "reset";

	// Reference model
	logic [`RV_XLEN-1:0] model_regs [`RV_NREGS];
	int issued;

	// Expected retires, oldest first
	logic exp_we_q [$];
	logic [RW-1:0] exp_rd_q [$];
	logic [`RV_XLEN-1:0] exp_data_q [$];
	logic exp_taken_q [$];

	rv_core_top rv_core_top_i (
		.clk_i          (clk),
		.rst_ni         (rst_n),
		.wb_cyc_i       (wb_cyc),
		.wb_stb_i       (wb_stb),
		.wb_we_i        (wb_we),
		.wb_adr_i       (wb_adr),
		.wb_dat_i       (wb_dat_w),
		.wb_dat_o       (wb_dat_r),
		.wb_ack_o       (wb_ack),
		.retire_valid_o (retire_valid),
		.retire_we_o    (retire_we),
		.retire_rd_o    (retire_rd),
		.retire_data_o  (retire_data),
		.branch_taken_o (branch_taken)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_retire(input logic exp_we, input logic [RW-1:0] exp_rd,
		input logic [`RV_XLEN-1:0] exp_data);
		if (retire_we !== exp_we) begin
			$display("CHECK FAILED %s: write flag expected %0b actual %0b",
				test_name, exp_we, retire_we);
			errors++;
		end else if (exp_we && (retire_rd !== exp_rd || retire_data !== exp_data)) begin
			$display("CHECK FAILED %s: expected x%0d=%h actual x%0d=%h",
				test_name, exp_rd, exp_data, retire_rd, retire_data);
			errors++;
		end
	endtask

	task automatic check_branch(input logic exp_taken);
		if (branch_taken !== exp_taken) begin
			$display("CHECK FAILED %s: branch taken expected %0b actual %0b",
				test_name, exp_taken, branch_taken);
			errors++;
		end
	endtask

	task automatic check_count(input logic [`RV_XLEN-1:0] exp_count,
		input logic [`RV_XLEN-1:0] act_count);
		if (act_count !== exp_count) begin
			$display("CHECK FAILED %s: retire count expected %0d actual %0d",
				test_name, exp_count, act_count);
			errors++;
		end
	endtask

	// Retire outputs are stable at the falling edge
	always @(negedge clk) begin
		if (rst_n && retire_valid) begin
			if (exp_we_q.size() == 0) begin
				$display("%s: retire seen with no instruction outstanding", test_name);
				errors++;
			end else begin
				check_retire(exp_we_q.pop_front(), exp_rd_q.pop_front(), exp_data_q.pop_front());
				check_branch(exp_taken_q.pop_front());
			end
		end
	end

	function automatic logic [`RV_XLEN-1:0] rand_word();
		return $random(seed);
	endfunction

	function automatic logic [31:0] r_insn(input rv_isa_pkg::rv_alu_op_e op,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {(op[3] ? 7'h20 : 7'h00), rs2, rs1, op[2:0], rd, rv_isa_pkg::OPC_OP};
	endfunction

	function automatic logic [31:0] i_insn(input logic [2:0] f3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [31:0] imm);
		return {imm[11:0], rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM};
	endfunction

	function automatic logic [31:0] u_insn(input rv_isa_pkg::rv_opcode_e opc,
		input logic [4:0] rd, input logic [31:0] imm);
		return {imm[19:0], rd, opc};
	endfunction

	function automatic logic [31:0] j_insn(input logic [4:0] rd, input logic [31:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::OPC_JAL};
	endfunction

	function automatic logic [31:0] b_insn(input rv_isa_pkg::rv_br_cond_e cond,
		input logic [4:0] rs1, input logic [4:0] rs2, input logic [31:0] off);
		return {off[12], off[10:5], rs2, rs1, cond, off[4:1], off[11], rv_isa_pkg::OPC_BRANCH};
	endfunction

	// ISA result of a funct3 operation
	function automatic logic [`RV_XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [`RV_XLEN-1:0] a, input logic [`RV_XLEN-1:0] b);
		logic [4:0] sh;
		sh = b[4:0];
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << sh;
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: return (a < b) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b101: return (a >> sh) | ((alt && a[31]) ? ~(32'hffffffff >> sh) : 32'h0);
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic void predict(input logic [31:0] insn);
		logic [6:0] opc;
		logic [RW-1:0] rd;
		logic [2:0] f3;
		logic [`RV_XLEN-1:0] a, b, pc, res;
		logic writes, taken;
		opc = insn[6:0];
		rd = insn[11:7];
		f3 = insn[14:12];
		a = model_regs[insn[19:15]];
		b = model_regs[insn[24:20]];
		pc = issued * 4;
		res = '0;
		writes = 1'b1;
		taken = 1'b0;
		case (opc)
			rv_isa_pkg::OPC_OP: res = alu_ref(f3, insn[30], a, b);
			rv_isa_pkg::OPC_OP_IMM: begin
				res = alu_ref(f3, insn[30] && f3 == 3'b101, a, {{20{insn[31]}}, insn[31:20]});
			end
			rv_isa_pkg::OPC_LUI: res = {insn[31:12], 12'b0};
			rv_isa_pkg::OPC_AUIPC: res = pc + {insn[31:12], 12'b0};
			rv_isa_pkg::OPC_JAL: res = pc + 32'd4;
			rv_isa_pkg::OPC_BRANCH: begin
				writes = 1'b0;
				case (f3)
					3'b000: taken = (a == b);
					3'b001: taken = (a != b);
					3'b100: taken = ($signed(a) < $signed(b));
					3'b101: taken = ($signed(a) >= $signed(b));
					3'b110: taken = (a < b);
					3'b111: taken = (a >= b);
					default: taken = 1'b0;
				endcase
			end
			default: writes = 1'b0; // Bubble
		endcase
		if (writes && rd != '0) begin
			model_regs[rd] = res;
		end
		exp_we_q.push_back(writes && rd != '0);
		exp_rd_q.push_back(rd);
		exp_data_q.push_back(res);
		exp_taken_q.push_back(taken);
		issued++;
	endfunction

	// Starts and ends just after a rising edge
	task automatic wait_ack(output logic [`RV_XLEN-1:0] rdata);
		int n;
		n = 0;
		@(negedge clk);
		while (!wb_ack && n < 8) begin
			@(negedge clk);
			n++;
		end
		if (!wb_ack) begin
			$display("%s: bus access to address %0h was never acknowledged", test_name, wb_adr);
			errors++;
		end
		rdata = wb_dat_r;
		@(posedge clk);
	endtask

	task automatic bus_write(input logic [`RV_XLEN-1:0] adr, input logic [`RV_XLEN-1:0] dat);
		logic [`RV_XLEN-1:0] unused;
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b1;
		wb_adr <= adr;
		wb_dat_w <= dat;
		wait_ack(unused);
	endtask

	task automatic bus_read(input logic [`RV_XLEN-1:0] adr, output logic [`RV_XLEN-1:0] dat);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b0;
		wb_adr <= adr;
		wait_ack(dat);
	endtask

	task automatic bus_idle();
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic issue(input logic [31:0] insn);
		predict(insn);
		bus_write(`RV_ADDR_INSN, insn);
	endtask

	task automatic load_const(input logic [4:0] rd, input logic [`RV_XLEN-1:0] val);
		logic [`RV_XLEN-1:0] upper;
		upper = (val + 32'h800) >> 12; // ADDI sign-extends the low part
		issue(u_insn(rv_isa_pkg::OPC_LUI, rd, upper));
		issue(i_insn(3'b000, rd, rd, val));
	endtask

	task automatic finish_test();
		int n;
		bus_idle();
		n = 0;
		while (exp_we_q.size() != 0 && n < 32) begin
			@(posedge clk);
			n++;
		end
		if (exp_we_q.size() != 0) begin
			$display("%s: %0d instructions never retired", test_name, exp_we_q.size());
			errors++;
			exp_we_q.delete();
			exp_rd_q.delete();
			exp_data_q.delete();
			exp_taken_q.delete();
		end
	endtask

	task automatic test_immediates();
		test_name = "immediates";
		load_const(5'd1, rand_word());
		issue(i_insn(3'b010, 5'd2, 5'd1, rand_word())); // SLTI
		issue(i_insn(3'b011, 5'd3, 5'd1, rand_word())); // SLTIU
		issue(i_insn(3'b100, 5'd4, 5'd1, rand_word()));
		issue(i_insn(3'b110, 5'd5, 5'd1, rand_word()));
		issue(i_insn(3'b111, 5'd6, 5'd1, rand_word()));
		issue(i_insn(3'b001, 5'd7, 5'd1, rand_word() & 32'h1f));
		issue(i_insn(3'b101, 5'd8, 5'd1, rand_word() & 32'h1f));
		issue(i_insn(3'b101, 5'd9, 5'd1, 32'h400 | (rand_word() & 32'h1f))); // SRAI
		issue(u_insn(rv_isa_pkg::OPC_LUI, 5'd10, rand_word()));
		issue(u_insn(rv_isa_pkg::OPC_AUIPC, 5'd11, rand_word()));
		issue(i_insn(3'b000, 5'd12, 5'd10, rand_word()));
		finish_test();
	endtask

	task automatic test_reg_ops();
		rv_isa_pkg::rv_alu_op_e ops [10];
		ops = '{rv_isa_pkg::ALU_ADD, rv_isa_pkg::ALU_SUB, rv_isa_pkg::ALU_SLL,
			rv_isa_pkg::ALU_SLT, rv_isa_pkg::ALU_SLTU, rv_isa_pkg::ALU_XOR,
			rv_isa_pkg::ALU_SRL, rv_isa_pkg::ALU_SRA, rv_isa_pkg::ALU_OR, rv_isa_pkg::ALU_AND};
		test_name = "register ops";
		load_const(5'd5, rand_word() & 32'h7fffffff);
		load_const(5'd6, rand_word() | 32'h80000000); // Sign differs from x5
		for (int k = 0; k < 10; k++) begin
			issue(r_insn(ops[k], 5'(10 + k), 5'd5, 5'd6));
			issue(r_insn(ops[k], 5'(20 + k), 5'd6, 5'd5));
		end
		// Dependent chain, each op reads the two previous results
		test_name = "forwarding";
		issue(i_insn(3'b000, 5'd1, 5'd0, rand_word()));
		issue(i_insn(3'b000, 5'd2, 5'd0, rand_word()));
		for (int k = 3; k < 16; k++) begin
			issue(r_insn(ops[k % 10], 5'(k), 5'(k - 1), 5'(k - 2)));
		end
		finish_test();
	endtask

	task automatic test_branches();
		logic [`RV_XLEN-1:0] a_vals [5];
		logic [`RV_XLEN-1:0] b_vals [5];
		rv_isa_pkg::rv_br_cond_e conds [6];
		conds = '{rv_isa_pkg::BR_BEQ, rv_isa_pkg::BR_BNE, rv_isa_pkg::BR_BLT,
			rv_isa_pkg::BR_BGE, rv_isa_pkg::BR_BLTU, rv_isa_pkg::BR_BGEU};
		a_vals[0] = rand_word();
		b_vals[0] = a_vals[0];
		a_vals[1] = 32'd3;
		b_vals[1] = 32'd7;
		a_vals[2] = 32'd7;
		b_vals[2] = 32'd3;
		a_vals[3] = 32'hfffffffb; // Negative against positive
		b_vals[3] = 32'd2;
		a_vals[4] = 32'd2;
		b_vals[4] = 32'hfffffffb;
		test_name = "branches";
		for (int p = 0; p < 5; p++) begin
			load_const(5'd20, a_vals[p]);
			load_const(5'd21, b_vals[p]);
			for (int c = 0; c < 6; c++) begin
				issue(b_insn(conds[c], 5'd20, 5'd21, rand_word() & 32'h1ffe));
			end
		end
		finish_test();
	endtask

	task automatic test_jal_x0();
		test_name = "jal and x0";
		issue(j_insn(5'd1, rand_word() & 32'h1ffffe));
		issue(j_insn(5'd0, 32'h8));
		issue(i_insn(3'b000, 5'd0, 5'd0, 32'h123)); // Dropped
		issue(r_insn(rv_isa_pkg::ALU_ADD, 5'd0, 5'd1, 5'd1));
		issue(r_insn(rv_isa_pkg::ALU_OR, 5'd8, 5'd0, 5'd0));
		issue(i_insn(3'b000, 5'd9, 5'd0, 32'h5));
		issue(r_insn(rv_isa_pkg::ALU_ADD, 5'd9, 5'd9, 5'd0));
		issue({20'h0, 5'd12, 7'b0000011}); // Load, unsupported
		issue(r_insn(rv_isa_pkg::ALU_ADD, 5'd13, 5'd12, 5'd0));
		finish_test();
	endtask

	task automatic test_count();
		logic [`RV_XLEN-1:0] count;
		test_name = "retire count";
		bus_read(`RV_ADDR_RETIRED, count);
		check_count(`RV_XLEN'(issued), count);
		bus_write(32'h5, i_insn(3'b000, 5'd1, 5'd0, 32'h7ff)); // Unused address
		bus_idle();
		repeat (8) @(posedge clk);
		bus_read(`RV_ADDR_RETIRED, count);
		check_count(`RV_XLEN'(issued), count);
		issue(r_insn(rv_isa_pkg::ALU_ADD, 5'd2, 5'd1, 5'd0)); // x1 still from before
		finish_test();
		bus_read(`RV_ADDR_RETIRED, count);
		check_count(`RV_XLEN'(issued), count);
		bus_idle();
	endtask

	initial begin
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		issued = 0;
		for (int i = 0; i < `RV_NREGS; i++) begin
			model_regs[i] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		test_immediates();
		test_reg_ops();
		test_branches();
		test_jal_x0();
		test_count();
		repeat (4) @(posedge clk);
		$display("Errors: %0d check, %0d assertion", errors, rv_core_top_i.rv_core_assert_i.fails);
		if (errors == 0 && rv_core_top_i.rv_core_assert_i.fails == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: tests still running after %0d ns", TIMEOUT_NS);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire
